/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // Word index into the peripheral register file
    typedef logic [3:0] bus_addr_t;

    // One load/store access from the CPU pipeline.
    // valid already includes the pipeline's load/store stage check.
    typedef struct packed {
        logic        valid;
        // Low for a load
        logic        store;
        bus_addr_t   addr;
        logic [31:0] wdata;
    } bus_req_t;

endpackage

`default_nettype wire

/* hw/periph_defines.svh */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Serial timing, kept short for simulation
`define PERIPH_CLKS_PER_BIT 8
`define PERIPH_FIFO_DEPTH   4

// Register map
`define PERIPH_ADDR_LED0    4'd0
`define PERIPH_ADDR_LED1    4'd1
`define PERIPH_ADDR_LED2    4'd2
`define PERIPH_ADDR_LED3    4'd3
`define PERIPH_ADDR_TX_DATA 4'd4
`define PERIPH_ADDR_TX_STAT 4'd5
`define PERIPH_ADDR_RX_DATA 4'd6
`define PERIPH_ADDR_RX_RDY  4'd7
`define PERIPH_ADDR_SW0     4'd8
`define PERIPH_ADDR_SW1     4'd9
`define PERIPH_ADDR_SW2     4'd10
`define PERIPH_ADDR_SW3     4'd11

`endif

/* hw/periph_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_defines.svh"

module periph_regs (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire bus_pkg::bus_req_t    bus_i,
    input  wire [3:0]                 sw_i,
    input  wire                       fifo_full_i,
    input  wire                       fifo_empty_i,
    input  wire                       tx_busy_i,
    input  wire uart_pkg::uart_byte_t rx_byte_i,
    input  wire                       rx_ready_i,
    output logic [31:0]               load_data_o,
    output logic [3:0]                led_o,
    output logic                      push_o,
    output uart_pkg::uart_byte_t      push_data_o,
    output logic                      rx_clear_o
);
    import uart_pkg::*;

    logic     is_load;
    logic     is_store;
    logic     tx_store;
    tx_stat_t tx_stat;

    assign is_load  = bus_i.valid && !bus_i.store;
    assign is_store = bus_i.valid && bus_i.store;
    assign tx_store = is_store && (bus_i.addr == `PERIPH_ADDR_TX_DATA);

    // Bytes still in the FIFO count as pending transmit work
    assign tx_stat.fifo_full = fifo_full_i;
    assign tx_stat.tx_busy   = !fifo_empty_i || tx_busy_i;

    // Reading the byte acknowledges it
    assign rx_clear_o = is_load && (bus_i.addr == `PERIPH_ADDR_RX_DATA);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            led_o  <= 4'b0000;
            push_o <= 1'b0;
        end else begin
            push_o <= tx_store;
            if (is_store) begin
                case (bus_i.addr)
                    `PERIPH_ADDR_LED0: led_o[0] <= |bus_i.wdata;
                    `PERIPH_ADDR_LED1: led_o[1] <= |bus_i.wdata;
                    `PERIPH_ADDR_LED2: led_o[2] <= |bus_i.wdata;
                    `PERIPH_ADDR_LED3: led_o[3] <= |bus_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Byte goes out together with the push strobe
    always_ff @(posedge clk_i) begin
        if (tx_store) begin
            push_data_o <= bus_i.wdata[7:0];
        end
    end

    // Load result holds until the next load
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            load_data_o <= 32'd0;
        end else if (is_load) begin
            case (bus_i.addr)
                `PERIPH_ADDR_TX_STAT: load_data_o <= {30'd0, tx_stat};
                `PERIPH_ADDR_RX_DATA: load_data_o <= {24'd0, rx_byte_i};
                `PERIPH_ADDR_RX_RDY:  load_data_o <= {31'd0, rx_ready_i};
                `PERIPH_ADDR_SW0:     load_data_o <= {31'd0, sw_i[0]};
                `PERIPH_ADDR_SW1:     load_data_o <= {31'd0, sw_i[1]};
                `PERIPH_ADDR_SW2:     load_data_o <= {31'd0, sw_i[2]};
                `PERIPH_ADDR_SW3:     load_data_o <= {31'd0, sw_i[3]};
                // Write-only and unmapped addresses
                default:              load_data_o <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire bus_pkg::bus_req_t bus_i,
    input  wire [3:0]              sw_i,
    input  wire                    uart_rxd_i,
    output logic [31:0]            load_data_o,
    output logic [3:0]             led_o,
    output logic                   uart_txd_o
);
    import uart_pkg::*;

    logic       fifo_full;
    logic       fifo_empty;
    logic       tx_busy;
    logic       push;
    uart_byte_t push_data;
    tx_hs_t     tx_hs;
    logic       tx_ack;
    uart_byte_t rx_byte;
    logic       rx_ready;
    logic       rx_clear;

    periph_regs u_regs (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .bus_i        (bus_i),
        .sw_i         (sw_i),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .tx_busy_i    (tx_busy),
        .rx_byte_i    (rx_byte),
        .rx_ready_i   (rx_ready),
        .load_data_o  (load_data_o),
        .led_o        (led_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .rx_clear_o   (rx_clear)
    );

    tx_fifo u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .hs_o        (tx_hs),
        .ack_i       (tx_ack)
    );

    uart_tx u_tx (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .hs_i       (tx_hs),
        .ack_o      (tx_ack),
        .busy_o     (tx_busy),
        .uart_txd_o (uart_txd_o)
    );

    // Receive path sits beside the transmit chain
    uart_rx u_rx (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .uart_rxd_i (uart_rxd_i),
        .clear_i    (rx_clear),
        .byte_o     (rx_byte),
        .ready_o    (rx_ready)
    );

endmodule

`default_nettype wire

/* hw/tx_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_defines.svh"

module tx_fifo (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       push_i,
    input  wire uart_pkg::uart_byte_t push_data_i,
    output logic                      full_o,
    output logic                      empty_o,
    output uart_pkg::tx_hs_t          hs_o,
    input  wire                       ack_i
);
    import uart_pkg::*;

    localparam int DEPTH = `PERIPH_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             req_q;
    logic             wr_en;
    logic             pop;

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

    // A push while full is lost
    assign wr_en = push_i && !full_o;
    // Ack seen with req still up marks the second phase
    assign pop   = req_q && ack_i;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            req_q  <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(pop);

            // Next request waits until ack has returned low
            if (pop) begin
                req_q <= 1'b0;
            end else if (!req_q && !ack_i && !empty_o) begin
                req_q <= 1'b1;
            end
        end
    end

    assign hs_o.req  = req_q;
    assign hs_o.data = mem[rd_ptr];

    // Request holds with stable data until the transmitter answers
    assert property (@(posedge clk_i) disable iff (reset_i)
        hs_o.req && !ack_i |=> hs_o.req && $stable(hs_o.data))
        else $error("tx_fifo request changed before ack");

endmodule

`default_nettype wire

/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // Layout of the TX_STAT word, bits 1:0
    typedef struct packed {
        logic fifo_full;
        logic tx_busy;
    } tx_stat_t;

    // FIFO side of the four-phase link to the transmitter
    typedef struct packed {
        logic       req;
        uart_byte_t data;
    } tx_hs_t;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_defines.svh"

module uart_rx (
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  wire                  uart_rxd_i,
    input  wire                  clear_i,
    output uart_pkg::uart_byte_t byte_o,
    output logic                 ready_o
);
    import uart_pkg::*;

    localparam int CLKS  = `PERIPH_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;
    logic             mid_start;
    logic             mid_bit;

    // Line idles high, so sync flops reset to 1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    assign mid_start = (clk_cnt == CNT_W'(CLKS / 2 - 1));
    assign mid_bit   = (clk_cnt == CNT_W'(CLKS - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            ready_o <= 1'b0;
        end else begin
            if (clear_i) begin
                ready_o <= 1'b0;
            end
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch rather than a start bit
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        shift_q <= {rxd_sync, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (mid_bit) begin
                        // Framing error drops the byte
                        if (rxd_sync) begin
                            byte_o  <= shift_q;
                            ready_o <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_defines.svh"

module uart_tx (
    input  wire                   clk_i,
    input  wire                   reset_i,
    input  wire uart_pkg::tx_hs_t hs_i,
    output logic                  ack_o,
    output logic                  busy_o,
    output logic                  uart_txd_o
);
    import uart_pkg::*;

    localparam int CLKS  = `PERIPH_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS - 1));
    assign busy_o  = (state != TX_IDLE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state      <= TX_IDLE;
            ack_o      <= 1'b0;
            uart_txd_o <= 1'b1;
            clk_cnt    <= '0;
            bit_idx    <= '0;
        end else begin
            // Fourth phase
            if (ack_o && !hs_i.req) begin
                ack_o <= 1'b0;
            end
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (hs_i.req && !ack_o) begin
                        // Latch the byte and ack as the start bit goes out
                        ack_o      <= 1'b1;
                        shift_q    <= hs_i.data;
                        uart_txd_o <= 1'b0;
                        state      <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        uart_txd_o <= shift_q[0];
                        shift_q    <= shift_q >> 1;
                        bit_idx    <= '0;
                        state      <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            uart_txd_o <= 1'b1;
                            state      <= TX_STOP;
                        end else begin
                            uart_txd_o <= shift_q[0];
                            shift_q    <= shift_q >> 1;
                            bit_idx    <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Request is still up in the cycle where ack first shows
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_o) |-> hs_i.req)
        else $error("uart_tx ack raised without a request");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_periph -f vlog.f

sim_out="$(./obj_dir/Vtb_periph 2>&1)" || { echo "$sim_out"; exit 1; }
echo "$sim_out"

echo "$sim_out" | grep -q "ALL TESTS PASSED"

/* sim/tb_periph.sv */
`timescale 1ns/10ps
`default_nettype none

`include "periph_defines.svh"

module tb_periph;
    import bus_pkg::*;
    import uart_pkg::*;

    localparam int CLKS         = `PERIPH_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * CLKS;
    localparam int POLL_LIMIT   = 200;

    logic        clk;
    logic        rst;
    bus_req_t    bus;
    logic [3:0]  sw;
    logic [31:0] load_data;
    logic [3:0]  led;
    logic        txd;

    logic [31:0] lfsr;
    uart_byte_t  exp_q[$];
    uart_byte_t  got_q[$];
    logic [3:0]  exp_led;

    // Serial output loops straight back into the receiver
    periph_top uut (
        .clk_i       (clk),
        .reset_i     (rst),
        .bus_i       (bus),
        .sw_i        (sw),
        .uart_rxd_i  (txd),
        .load_data_o (load_data),
        .led_o       (led),
        .uart_txd_o  (txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            report_fail($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic store_word(input bus_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        bus = '{valid: 1'b1, store: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        bus = '0;
    endtask

    // Registered result is read one cycle after the access
    task automatic load_word(input bus_addr_t addr, output logic [31:0] data);
        @(negedge clk);
        bus = '{valid: 1'b1, store: 1'b0, addr: addr, wdata: 32'd0};
        @(negedge clk);
        bus  = '0;
        data = load_data;
    endtask

    task automatic wait_frames(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < n * FRAME_CYCLES * 2 + 50) begin
            @(negedge clk);
            cycles++;
        end
        if (got_q.size() < n) begin
            report_fail("timeout waiting for serial frames on the transmit line");
        end
    endtask

    task automatic wait_tx_idle();
        logic [31:0] stat;
        int          polls;
        polls = 0;
        stat  = 32'hffff_ffff;
        while (stat != 32'd0 && polls < POLL_LIMIT) begin
            load_word(`PERIPH_ADDR_TX_STAT, stat);
            polls++;
        end
        if (stat != 32'd0) begin
            report_fail("timeout waiting for the transmitter to go idle");
        end
    endtask

    task automatic compare_frames(input string name);
        uart_byte_t exp_byte;
        uart_byte_t got_byte;
        while (exp_q.size() > 0) begin
            exp_byte = exp_q.pop_front();
            got_byte = got_q.pop_front();
            check_value(name, {24'd0, exp_byte}, {24'd0, got_byte});
        end
        check_value({name, "_count"}, 32'd0, got_q.size());
    endtask

    // Samples near bit centers as counted from the start edge
    task automatic capture_frame();
        uart_byte_t data;
        repeat (CLKS / 2 - 1) @(negedge clk);
        check_value("frame_start", 32'd0, {31'd0, txd});
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            data[i] = txd;
        end
        repeat (CLKS) @(negedge clk);
        check_value("frame_stop", 32'd1, {31'd0, txd});
        got_q.push_back(data);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && txd === 1'b0) begin
                capture_frame();
            end
        end
    end

    // Load result only moves at the edge that samples a load
    assert property (@(posedge clk) disable iff (rst)
        !$past(bus.valid && !bus.store) |-> $stable(load_data))
        else report_fail("load_data_o changed without a load");

    initial begin
        logic [31:0] val;
        logic [31:0] rdata;
        uart_byte_t  exp_byte;
        int          polls;

        bus     = '0;
        sw      = 4'h0;
        rst     = 1'b1;
        lfsr    = 32'h53efa075;
        exp_led = 4'h0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("reset_led", 32'd0, {28'd0, led});
        check_value("reset_load_data", 32'd0, load_data);
        check_value("reset_txd", 32'd1, {31'd0, txd});

        // Each LED goes on with a nonzero word and off with zero
        for (int i = 0; i < 4; i++) begin
            take_bits(32, val);
            store_word(bus_addr_t'(`PERIPH_ADDR_LED0 + i), val);
            exp_led[i] = (val != 32'd0);
            check_value($sformatf("led%0d_set", i), {28'd0, exp_led}, {28'd0, led});
            store_word(bus_addr_t'(`PERIPH_ADDR_LED0 + i), 32'd0);
            exp_led[i] = 1'b0;
            check_value($sformatf("led%0d_clear", i), {28'd0, exp_led}, {28'd0, led});
        end
        for (int i = 0; i < 4; i += 2) begin
            store_word(bus_addr_t'(`PERIPH_ADDR_LED0 + i), 32'h8000_0000);
            exp_led[i] = 1'b1;
        end
        check_value("led_pattern", {28'd0, exp_led}, {28'd0, led});

        // Switch bits
        for (int n = 0; n < 4; n++) begin
            take_bits(4, val);
            @(negedge clk);
            sw = val[3:0];
            for (int i = 0; i < 4; i++) begin
                load_word(bus_addr_t'(`PERIPH_ADDR_SW0 + i), rdata);
                check_value($sformatf("switch%0d", i), {31'd0, val[i]}, rdata);
            end
        end

        // Each unmapped read follows a read that returned one
        @(negedge clk);
        sw = 4'hf;
        for (int a = 12; a < 16; a++) begin
            load_word(`PERIPH_ADDR_SW0, rdata);
            load_word(bus_addr_t'(a), rdata);
            check_value($sformatf("unmapped%0d", a), 32'd0, rdata);
        end

        // Transmit framing and order
        for (int n = 0; n < 3; n++) begin
            take_bits(32, val);
            exp_q.push_back(val[7:0]);
            store_word(`PERIPH_ADDR_TX_DATA, val);
        end
        wait_frames(3);
        compare_frames("tx_frame");

        // Back-pressure with one byte in flight and four buffered
        wait_tx_idle();
        for (int n = 0; n < 5; n++) begin
            take_bits(32, val);
            exp_q.push_back(val[7:0]);
            store_word(`PERIPH_ADDR_TX_DATA, val);
        end
        polls = 0;
        rdata = 32'd0;
        while (!rdata[1] && polls < POLL_LIMIT) begin
            load_word(`PERIPH_ADDR_TX_STAT, rdata);
            polls++;
        end
        check_value("tx_stat_full", 32'h3, rdata);
        take_bits(32, val);
        store_word(`PERIPH_ADDR_TX_DATA, val);
        wait_frames(5);
        compare_frames("backpressure");
        for (int c = 0; c < 3 * FRAME_CYCLES; c++) begin
            @(negedge clk);
        end
        check_value("dropped_byte", 32'd0, got_q.size());

        // Stale byte is cleared before the loopback receive
        load_word(`PERIPH_ADDR_RX_DATA, rdata);
        load_word(`PERIPH_ADDR_RX_RDY, rdata);
        check_value("rx_rdy_stale", 32'd0, rdata);
        take_bits(32, val);
        exp_byte = val[7:0];
        exp_q.push_back(exp_byte);
        store_word(`PERIPH_ADDR_TX_DATA, val);
        wait_frames(1);
        compare_frames("loopback_tx");
        polls = 0;
        rdata = 32'd0;
        while (rdata == 32'd0 && polls < POLL_LIMIT) begin
            load_word(`PERIPH_ADDR_RX_RDY, rdata);
            polls++;
        end
        check_value("rx_rdy_set", 32'd1, rdata);
        load_word(`PERIPH_ADDR_RX_DATA, rdata);
        check_value("rx_data", {24'd0, exp_byte}, rdata);
        load_word(`PERIPH_ADDR_RX_RDY, rdata);
        check_value("rx_rdy_after_read", 32'd0, rdata);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/bus_pkg.sv
hw/uart_pkg.sv
hw/periph_regs.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/periph_top.sv
sim/tb_periph.sv
